//--- i2c_pkg.sv
package i2c_pkg;

    // First byte after START as seen on the wire, MSB first
    typedef struct packed {
        logic [6:0] addr;   // 7-bit target address
        logic       rw;     // 0 = write, 1 = read
    } i2c_header_t;

    // One bus byte, either the header or a payload byte
    typedef union packed {
        i2c_header_t header;    // Decoded as address + rw
        logic [7:0]  data;      // Decoded as plain data
    } i2c_byte_u;

    // Master transfer FSM
    typedef enum logic [2:0] {
        IDLE       = 3'd0,  // Waiting for a start request
        START      = 3'd1,  // SDA falls while SCL is high
        SEND_BIT   = 3'd2,  // Shift out header or data
        CHECK_ACK  = 3'd3,  // Sample the target ACK
        READ_SLAVE = 3'd4,  // Shift in a byte from the target
        WRITE_ACK  = 3'd5,  // Drive ack_master onto SDA
        STOP       = 3'd6,  // SDA rises while SCL is high
        DONE       = 3'd7   // Bus released, done pulse
    } i2c_state_e;

endpackage

//--- i2c_bus_if.sv
`timescale 1ns/1ps

interface i2c_bus_if #(
    parameter int NUM_TARGETS = 4
);

    logic                   scl_pull_m;     // Master pulls SCL low
    logic                   sda_pull_m;     // Master pulls SDA low
    wire  [NUM_TARGETS-1:0] sda_pull_t;     // One SDA pull per target
    logic                   scl;            // Resolved SCL level
    logic                   sda;            // Resolved SDA level

    modport master (
        output scl_pull_m, sda_pull_m,
        input  scl, sda
    );

    modport target (
        output sda_pull_t,
        input  scl, sda
    );

    modport monitor (
        input  scl_pull_m, sda_pull_m, sda_pull_t,
        output scl, sda
    );

endinterface

//--- i2c_master.sv
`timescale 1ns/1ps

module i2c_master #(
    parameter int CLK_FREQ = 100_000_000,
    parameter int SCL_FREQ = 5_000_000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,           // One-cycle request
    input  logic [6:0] slave_addr,
    input  logic       rw,              // 0 = write, 1 = read
    input  logic [7:0] data_in,         // Reloaded after every ACK in a write
    input  logic       ack_master,      // 0 = ACK and go on, 1 = NACK and stop
    output logic [7:0] data_slave,
    output logic       done,
    output logic       nack,            // Header byte not acknowledged
    i2c_bus_if.master  bus
);
    import i2c_pkg::*;

    localparam int SCL_DIV = CLK_FREQ / (2 * SCL_FREQ);    // clk cycles per SCL half period
    localparam int CNT_W   = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;

    logic [CNT_W-1:0] clk_counter;
    logic             scl_out;          // Free-running internal SCL
    logic             scl_last;
    logic             scl_rise;
    logic             scl_fall;         // Paces the FSM
    i2c_state_e       state;
    i2c_state_e       next_state;
    logic [2:0]       bit_index;        // Bit on the wire, MSB first
    i2c_byte_u        shift_reg;
    logic             sda_out;
    logic             sda_dir;          // 1 = master owns SDA
    logic             scl_dir;          // 1 = master owns SCL
    logic             start_id;         // Pending start request
    logic             check_ack_slave;
    logic             rw_q;             // Direction of the running transfer
    logic             hdr_phase;        // Current byte is the header

    assign scl_rise = ~scl_last & scl_out;
    assign scl_fall = scl_last & ~scl_out;

    // Open drain: only low levels are driven
    assign bus.scl_pull_m = scl_dir & ~scl_out;
    assign bus.sda_pull_m = sda_dir & ~sda_out;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clk_counter <= '0;
            scl_out     <= 1'b1;                    // SCL idles high
            scl_last    <= 1'b1;
        end else begin
            scl_last <= scl_out;
            if (clk_counter == CNT_W'(SCL_DIV - 1)) begin
                clk_counter <= '0;
                scl_out     <= ~scl_out;            // Half period elapsed
            end else begin
                clk_counter <= clk_counter + 1'b1;
            end
        end
    end

    // Request held until the FSM leaves IDLE, so a start during a transfer waits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_id <= 1'b0;
        end else if (start) begin
            start_id <= 1'b1;
        end else if (state == IDLE) begin
            start_id <= 1'b0;                       // Consumed on IDLE -> START
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:       if (start_id) next_state = START;
            START:      if (scl_fall && !sda_out) next_state = SEND_BIT;    // START issued first
            SEND_BIT:   if (scl_fall && bit_index == 3'd0) next_state = CHECK_ACK;
            CHECK_ACK: begin
                if (scl_fall) begin
                    if (!check_ack_slave) next_state = STOP;                // NACK ends it
                    else if (rw_q) next_state = READ_SLAVE;
                    else next_state = SEND_BIT;
                end
            end
            READ_SLAVE: if (scl_fall && bit_index == 3'd0) next_state = WRITE_ACK;
            WRITE_ACK:  if (scl_fall) next_state = sda_out ? STOP : READ_SLAVE;
            STOP:       if (scl_fall) next_state = DONE;
            DONE:       if (scl_rise) next_state = IDLE;                    // Half period of done
            default:    next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sda_out         <= 1'b1;
            sda_dir         <= 1'b0;
            scl_dir         <= 1'b0;
            done            <= 1'b0;
            nack            <= 1'b0;
            check_ack_slave <= 1'b0;
            shift_reg       <= '0;
            bit_index       <= 3'd7;
            data_slave      <= 8'h00;
            rw_q            <= 1'b0;
            hdr_phase       <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    sda_out         <= 1'b1;        // Lines released
                    sda_dir         <= 1'b0;
                    scl_dir         <= 1'b0;
                    done            <= 1'b0;
                    check_ack_slave <= 1'b0;
                    bit_index       <= 3'd7;
                end
                START: begin
                    if (scl_rise) sda_out <= 1'b0;  // SDA falls well inside SCL high
                    sda_dir                 <= 1'b1;
                    scl_dir                 <= 1'b1;
                    shift_reg.header.addr   <= slave_addr;
                    shift_reg.header.rw     <= rw;
                    rw_q                    <= rw;
                    hdr_phase               <= 1'b1;
                    nack                    <= 1'b0;    // Previous result dropped
                    data_slave              <= 8'h00;
                    bit_index               <= 3'd7;
                end
                SEND_BIT: begin
                    sda_out <= shift_reg.data[bit_index];
                    sda_dir <= 1'b1;
                    if (scl_fall && bit_index != 3'd0) bit_index <= bit_index - 3'd1;
                end
                CHECK_ACK: begin
                    sda_dir   <= 1'b0;              // Target owns SDA for the ACK bit
                    bit_index <= 3'd7;
                    if (scl_rise) begin
                        check_ack_slave <= ~bus.sda;
                        if (!bus.sda && !rw_q) shift_reg.data <= data_in;   // Next write byte
                    end else if (scl_fall) begin
                        check_ack_slave <= 1'b0;
                        hdr_phase       <= 1'b0;
                        if (hdr_phase && !check_ack_slave) nack <= 1'b1;   // Nobody answered
                    end
                end
                READ_SLAVE: begin
                    sda_dir <= 1'b0;
                    if (scl_rise) data_slave[bit_index] <= bus.sda;
                    if (scl_fall && bit_index != 3'd0) bit_index <= bit_index - 3'd1;
                end
                WRITE_ACK: begin
                    sda_dir   <= 1'b1;
                    bit_index <= 3'd7;
                    if (!scl_out) sda_out <= ack_master;    // Frozen while SCL is high
                end
                STOP: begin
                    if (!scl_out && next_state == STOP) begin
                        sda_dir <= 1'b1;            // Hold SDA low during SCL low
                        sda_out <= 1'b0;
                    end else if (scl_out) begin
                        sda_out <= 1'b1;            // SDA rises with SCL high
                        sda_dir <= 1'b0;
                    end
                end
                DONE: begin
                    done    <= 1'b1;
                    sda_out <= 1'b1;
                    sda_dir <= 1'b0;
                    scl_dir <= 1'b0;                // SCL back to idle high
                end
                default: sda_dir <= 1'b0;
            endcase
        end
    end

endmodule

//--- i2c_target.sv
`timescale 1ns/1ps

module i2c_target #(
    parameter logic [6:0] ADDRESS = 7'h50,
    parameter int         INDEX   = 0
) (
    input  logic      clk,
    input  logic      reset,
    i2c_bus_if.target bus
);
    import i2c_pkg::*;

    localparam logic [2:0] T_IDLE = 3'd0;   // Not addressed
    localparam logic [2:0] T_RX   = 3'd1;   // Shifting in header or write data
    localparam logic [2:0] T_ACK  = 3'd2;   // Driving our ACK or NACK bit
    localparam logic [2:0] T_TX   = 3'd3;   // Shifting out the stored byte
    localparam logic [2:0] T_MACK = 3'd4;   // Reading the master ACK

    logic [2:0] state;
    logic       scl_q, sda_q;
    logic       scl_rise, scl_fall, start_cond, stop_cond;
    logic [3:0] bit_cnt;                    // Bits moved in the current byte
    logic       hdr;                        // Byte in flight is the header
    logic       first;                      // Next write byte is the one we keep
    logic       rd_mode;
    logic       mack;                       // Level sampled in the master ACK slot
    logic       sda_pull;
    logic       tx_load;
    logic [7:0] store;                      // The register itself
    i2c_byte_u  rx;
    logic [7:0] tx_sh;

    assign scl_rise   = bus.scl & ~scl_q;
    assign scl_fall   = ~bus.scl & scl_q;
    assign start_cond = scl_q & bus.scl & sda_q & ~bus.sda;
    assign stop_cond  = scl_q & bus.scl & ~sda_q & bus.sda;
    // Start of each read byte, after the header ACK or a master ACK
    assign tx_load = scl_fall & (((state == T_ACK) & hdr & rd_mode) |
                                 ((state == T_MACK) & ~mack));

    assign bus.sda_pull_t[INDEX] = sda_pull;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= T_IDLE;
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
            bit_cnt  <= 4'd0;
            hdr      <= 1'b0;
            first    <= 1'b0;
            rd_mode  <= 1'b0;
            mack     <= 1'b1;
            sda_pull <= 1'b0;
            store    <= 8'h00;
        end else begin
            scl_q <= bus.scl;
            sda_q <= bus.sda;
            if (start_cond) begin
                state    <= T_RX;               // Header comes next
                bit_cnt  <= 4'd0;
                hdr      <= 1'b1;
                sda_pull <= 1'b0;
            end else if (stop_cond) begin
                state    <= T_IDLE;
                sda_pull <= 1'b0;
            end else if (tx_load) begin
                state    <= T_TX;
                sda_pull <= ~store[7];          // MSB goes out while SCL is low
                bit_cnt  <= 4'd1;
                hdr      <= 1'b0;
            end else begin
                case (state)
                    T_RX: begin
                        if (scl_rise) begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end else if (scl_fall && bit_cnt == 4'd8) begin
                            bit_cnt <= 4'd0;
                            if (!hdr) begin
                                sda_pull <= first;          // Only the first byte is ACKed
                                first    <= 1'b0;
                                state    <= T_ACK;
                                if (first) store <= rx.data;
                            end else if (rx.header.addr == ADDRESS) begin
                                rd_mode  <= rx.header.rw;
                                first    <= 1'b1;
                                sda_pull <= 1'b1;           // ACK our address
                                state    <= T_ACK;
                            end else begin
                                state <= T_IDLE;            // Someone else's transfer
                            end
                        end
                    end
                    T_ACK: begin
                        if (scl_fall) begin
                            hdr      <= 1'b0;
                            sda_pull <= 1'b0;
                            state    <= T_RX;
                        end
                    end
                    T_TX: begin
                        if (scl_fall && bit_cnt == 4'd8) begin
                            sda_pull <= 1'b0;               // Free SDA for the master ACK
                            state    <= T_MACK;
                        end else if (scl_fall) begin
                            sda_pull <= ~tx_sh[6];
                            bit_cnt  <= bit_cnt + 4'd1;
                        end
                    end
                    T_MACK: begin
                        if (scl_rise) mack <= bus.sda;
                        else if (scl_fall) state <= T_IDLE; // NACK, STOP follows
                    end
                    default: state <= T_IDLE;
                endcase
            end
        end
    end

    // Shift registers
    always_ff @(posedge clk) begin
        if (state == T_RX && scl_rise) rx.data <= {rx.data[6:0], bus.sda};
        if (tx_load) tx_sh <= store;
        else if (state == T_TX && scl_fall) tx_sh <= {tx_sh[6:0], 1'b0};
    end

endmodule

//--- i2c_bus_monitor.sv
`timescale 1ns/1ps

module i2c_bus_monitor (
    input  logic       clk,
    input  logic       reset,
    i2c_bus_if.monitor bus,
    output logic       bus_busy         // High between START and STOP
);

    logic scl_q;                        // Line levels one cycle back
    logic sda_q;
    logic start_seen;
    logic stop_seen;

    // Wired-AND, a line is low as soon as anyone pulls it
    assign bus.scl = ~bus.scl_pull_m;
    assign bus.sda = ~(bus.sda_pull_m | (|bus.sda_pull_t));

    assign start_seen = scl_q & bus.scl & sda_q & ~bus.sda;    // SDA falls, SCL high
    assign stop_seen  = scl_q & bus.scl & ~sda_q & bus.sda;    // SDA rises, SCL high

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
            bus_busy <= 1'b0;
        end else begin
            scl_q <= bus.scl;
            sda_q <= bus.sda;
            if (start_seen) begin
                bus_busy <= 1'b1;
            end else if (stop_seen) begin
                bus_busy <= 1'b0;
            end
        end
    end

endmodule

//--- i2c_subsystem.sv
`timescale 1ns/1ps

module i2c_subsystem #(
    parameter int         CLK_FREQ    = 100_000_000,
    parameter int         SCL_FREQ    = 5_000_000,
    parameter int         NUM_TARGETS = 4,
    parameter logic [6:0] BASE_ADDR   = 7'h50     // Address of target 0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [6:0] slave_addr,
    input  logic       rw,
    input  logic [7:0] data_in,
    input  logic       ack_master,
    output logic [7:0] data_slave,
    output logic       done,
    output logic       nack,
    output logic       bus_busy
);

    i2c_bus_if #(.NUM_TARGETS(NUM_TARGETS)) bus ();

    i2c_master #(
        .CLK_FREQ (CLK_FREQ),
        .SCL_FREQ (SCL_FREQ)
    ) master_inst (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .slave_addr (slave_addr),
        .rw         (rw),
        .data_in    (data_in),
        .ack_master (ack_master),
        .data_slave (data_slave),
        .done       (done),
        .nack       (nack),
        .bus        (bus.master)
    );

    // Consecutive addresses from BASE_ADDR
    for (genvar i = 0; i < NUM_TARGETS; i++) begin : g_target
        i2c_target #(
            .ADDRESS (BASE_ADDR + 7'(i)),
            .INDEX   (i)
        ) target_inst (
            .clk   (clk),
            .reset (reset),
            .bus   (bus.target)
        );
    end

    i2c_bus_monitor monitor_inst (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus.monitor),
        .bus_busy (bus_busy)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;     // Free-running clock
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;                              // Released on a rising edge
    end

endmodule

//--- i2c_subsystem_properties.sv
`timescale 1ns/1ps

module i2c_subsystem_properties (
    input logic                clk,
    input logic                reset,
    input logic                scl,             // Resolved bus levels
    input logic                sda,
    input i2c_pkg::i2c_state_e master_state,
    input logic                done,
    input logic                nack,
    input logic                bus_busy,
    input logic [7:0]          data_slave
);
    import i2c_pkg::*;

    int sda_fail  = 0;
    int done_fail = 0;
    int x_fail    = 0;
    int busy_fail = 0;
    int fail_count;                             // Total of all failed properties

    assign fail_count = sda_fail + done_fail + x_fail + busy_fail;

    // SDA moves during SCL high only for START and STOP
    sda_stable_a: assert property (@(posedge clk) disable iff (reset)
        (scl && $past(scl) && (sda != $past(sda))) |-> (master_state inside {START, STOP}))
        else begin
            $error("SDA changed while SCL was high outside START or STOP");
            sda_fail = sda_fail + 1;
        end

    // STOP precedes the done pulse
    done_idle_a: assert property (@(posedge clk) disable iff (reset)
        done |-> !bus_busy)
        else begin
            $error("done is high while the bus is still busy");
            done_fail = done_fail + 1;
        end

    outputs_known_a: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({done, nack, bus_busy, data_slave}))
        else begin
            $error("An output of the subsystem is unknown");
            x_fail = x_fail + 1;
        end

    // Bits only move inside a START/STOP frame
    busy_in_frame_a: assert property (@(posedge clk) disable iff (reset)
        (master_state inside {SEND_BIT, CHECK_ACK, READ_SLAVE, WRITE_ACK}) |-> bus_busy)
        else begin
            $error("Master shifts bits while the monitor sees an idle bus");
            busy_fail = busy_fail + 1;
        end

endmodule

bind i2c_subsystem i2c_subsystem_properties props_inst (
    .clk          (clk),
    .reset        (reset),
    .scl          (bus.scl),
    .sda          (bus.sda),
    .master_state (master_inst.state),
    .done         (done),
    .nack         (nack),
    .bus_busy     (bus_busy),
    .data_slave   (data_slave)
);

//--- tb_i2c_subsystem.sv
`timescale 1ns/1ps

module tb_i2c_subsystem;

    localparam int          CLK_FREQ    = 100_000_000;
    localparam int          SCL_FREQ    = 5_000_000;
    localparam int          NUM_TARGETS = 4;
    localparam logic [6:0]  BASE_ADDR   = 7'h50;
    localparam int          SCL_DIV     = CLK_FREQ / (2 * SCL_FREQ);
    localparam int          NUM_XFERS   = 5 + 3 * NUM_TARGETS;          // Transfers of all tests
    localparam int          TIMEOUT     = NUM_XFERS * 40 * SCL_DIV * 2; // Two times the estimate
    localparam logic [31:0] SEED        = 32'hc966173f;

    logic       clk;
    logic       reset;
    logic       start;
    logic [6:0] slave_addr;
    logic       rw;
    logic [7:0] data_in;
    logic       ack_master;
    logic [7:0] data_slave;
    logic       done;
    logic       nack;
    logic       bus_busy;

    logic [7:0] model [NUM_TARGETS];            // Last byte written to each target
    int         errors;
    int         tests_run;
    int         tests_failed;
    int         test_base;                      // Error count when the test began
    int         cycle_count = 0;
    bit         busy_seen;                      // bus_busy went high in the last transfer

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(2)) clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    i2c_subsystem #(
        .CLK_FREQ    (CLK_FREQ),
        .SCL_FREQ    (SCL_FREQ),
        .NUM_TARGETS (NUM_TARGETS),
        .BASE_ADDR   (BASE_ADDR)
    ) i2c_subsystem_inst (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .slave_addr (slave_addr),
        .rw         (rw),
        .data_in    (data_in),
        .ack_master (ack_master),
        .data_slave (data_slave),
        .done       (done),
        .nack       (nack),
        .bus_busy   (bus_busy)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout after %0d cycles, a transfer never signalled done", TIMEOUT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic expect_equal(input string test, input string what,
                                input logic [7:0] expected, input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("** Error %s: %s expected %02h, actual %02h", test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic expect_true(input string test, input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("Failure in %s: %s", test, what);
            errors++;
        end
    endtask

    // Fields stay on the ports until the next request
    task automatic request(input logic [6:0] addr, input logic dir,
                           input logic [7:0] data, input logic ack);
        while (done) @(negedge clk);            // Previous done pulse over
        @(posedge clk);
        start      <= 1'b1;
        slave_addr <= addr;
        rw         <= dir;
        data_in    <= data;
        ack_master <= ack;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        busy_seen = 1'b0;
        do begin
            @(negedge clk);
            if (bus_busy) busy_seen = 1'b1;
        end while (!done);
    endtask

    task automatic write_target(input string test, input int idx, input logic [7:0] value);
        request(BASE_ADDR + 7'(idx), 1'b0, value, 1'b1);
        wait_done();
        model[idx] = value;                     // Target keeps the first data byte
        expect_equal(test, $sformatf("nack of write to target %0d", idx), 8'h00, {7'b0, nack});
    endtask

    // Single-byte read, NACKed by the master
    task automatic read_target(input string test, input int idx);
        request(BASE_ADDR + 7'(idx), 1'b1, 8'h00, 1'b1);
        wait_done();
        expect_equal(test, $sformatf("read of target %0d", idx), model[idx], data_slave);
        expect_equal(test, $sformatf("nack of read from target %0d", idx), 8'h00, {7'b0, nack});
    endtask

    function automatic bit byte_taken(input logic [7:0] value, input int count);
        bit taken;
        taken = 1'b0;
        for (int j = 0; j < count; j++) begin
            if (model[j] == value) taken = 1'b1;
        end
        return taken;
    endfunction

    task automatic end_test(input string test);
        tests_run++;
        if (errors == test_base) begin
            $display("test %s: ok", test);
        end else begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", test, errors - test_base);
        end
    endtask

    initial begin
        int         idx;
        int         periods;
        logic [7:0] value;
        start        = 1'b0;
        slave_addr   = 7'h00;
        rw           = 1'b0;
        data_in      = 8'h00;
        ack_master   = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(SEED));
        for (int i = 0; i < NUM_TARGETS; i++) model[i] = 8'h00;    // Targets reset to zero

        @(posedge clk);
        while (reset) @(posedge clk);
        @(negedge clk);

        test_base = errors;
        expect_equal("reset_values", "done", 8'h00, {7'b0, done});
        expect_equal("reset_values", "nack", 8'h00, {7'b0, nack});
        expect_equal("reset_values", "bus_busy", 8'h00, {7'b0, bus_busy});
        expect_equal("reset_values", "data_slave", 8'h00, data_slave);
        end_test("reset_values");

        test_base = errors;
        idx = $urandom_range(NUM_TARGETS - 1, 0);
        write_target("write_read", idx, 8'($urandom));
        read_target("write_read", idx);
        end_test("write_read");

        // Distinct bytes so a crossed address shows up
        test_base = errors;
        for (int i = 0; i < NUM_TARGETS; i++) begin
            value = 8'($urandom);
            while (byte_taken(value, i)) value = 8'($urandom);
            write_target("independence", i, value);
        end
        for (int i = 0; i < NUM_TARGETS; i++) read_target("independence", i);
        end_test("independence");

        test_base = errors;
        request(BASE_ADDR + 7'(NUM_TARGETS), 1'b0, 8'($urandom), 1'b1);
        wait_done();
        expect_equal("unknown_address", "nack", 8'h01, {7'b0, nack});
        for (int i = 0; i < NUM_TARGETS; i++) read_target("unknown_address", i);
        end_test("unknown_address");

        // Master ACKs bytes for a while, then NACKs the one in flight
        test_base = errors;
        idx     = $urandom_range(NUM_TARGETS - 1, 0);
        periods = $urandom_range(40, 24);       // Past the first data byte, two or more bytes
        request(BASE_ADDR + 7'(idx), 1'b1, 8'h00, 1'b0);
        repeat (periods * 2 * SCL_DIV) @(posedge clk);
        ack_master <= 1'b1;
        wait_done();
        expect_equal("multi_byte_read", "data_slave", model[idx], data_slave);
        expect_equal("multi_byte_read", "nack", 8'h00, {7'b0, nack});
        end_test("multi_byte_read");

        test_base = errors;
        idx = $urandom_range(NUM_TARGETS - 1, 0);
        write_target("bus_busy", idx, 8'($urandom));
        expect_true("bus_busy", busy_seen, "bus_busy never went high after start");
        expect_equal("bus_busy", "bus_busy at done", 8'h00, {7'b0, bus_busy});
        end_test("bus_busy");

        $display("Tests run %0d, failed %0d, check errors %0d, property failures %0d",
                 tests_run, tests_failed, errors, i2c_subsystem_inst.props_inst.fail_count);
        if (errors == 0 && i2c_subsystem_inst.props_inst.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
i2c_pkg.sv
i2c_bus_if.sv
i2c_master.sv
i2c_target.sv
i2c_bus_monitor.sv
i2c_subsystem.sv
tb_clock_gen.sv
i2c_subsystem_properties.sv
tb_i2c_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the I2C subsystem testbench with Verilator, run it, then scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_i2c_subsystem -f filelist.f -o sim_i2c

./obj_dir/sim_i2c +verilator+error+limit+1000 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "run_sim.sh: failure reported in sim.log"
    exit 1
fi
echo "run_sim.sh: no failure reported in sim.log"
